//--- sim/tag_manager_testdata.txt
# op arg value  (W addr data, R addr expected, I payload expected_tag, T tag expected_payload)
# all fields hex
W 0 0004
R 0 0004
R 1 0004
I a101 1
I a202 2
I a303 3
R 1 0001
T 2 a202
R 1 0002
I a404 2
I a505 4
R 1 0000
I a606 3
T 3 a303
T 1 a101
R 1 0001
T 1 a101
R 2 0001
W 2 0001
R 2 0000
W 0 0004
R 1 0004

//--- compile.f
source/tag_pkg.sv
source/slot_keeper.sv
source/tag_cfg_regs.sv
source/tag_issue.sv
source/tag_context.sv
source/tag_retire.sv
source/tag_manager_top.sv
sim/tag_manager_checker.sv
sim/tag_manager_asserts.sv
sim/tag_manager_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tag_manager_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) | awk '{ print } /^=== PASS ===$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

//--- sim/tag_manager_tb.sv
`timescale 1ns/1ps

module tag_manager_tb;

  import tag_pkg::*;

  localparam int    RESET_CYCLES    = 16;
  localparam int    CYCLES_PER_LINE = 40;
  localparam string TESTDATA        = "sim/tag_manager_testdata.txt";

  logic                      clk;
  logic                      rst;
  logic                      cfg_req;
  logic                      cfg_write;
  logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
  logic [PAYLOAD_WIDTH-1:0]  cfg_wdata;
  logic                      cfg_ack;
  logic [PAYLOAD_WIDTH-1:0]  cfg_rdata;
  logic                      iss_req;
  logic [PAYLOAD_WIDTH-1:0]  iss_payload;
  logic                      iss_ack;
  logic [SLOT_WIDTH-1:0]     iss_tag;
  logic                      ret_req;
  logic [SLOT_WIDTH-1:0]     ret_tag;
  logic                      ret_ack;
  logic [PAYLOAD_WIDTH-1:0]  ret_payload;

  logic [PAYLOAD_WIDTH-1:0]  exp_cfg;
  logic [SLOT_WIDTH-1:0]     exp_tag;
  logic [PAYLOAD_WIDTH-1:0]  exp_payload;
  int                        pass_count;
  int                        error_count;

  logic [7:0]                op_q [$];
  logic [PAYLOAD_WIDTH-1:0]  arg_q [$];
  logic [PAYLOAD_WIDTH-1:0]  val_q [$];
  int                        cycle_limit = 0;
  int                        cycle_count;
  int                        expected_checks;
  int                        bad_lines;
  logic                      loaded;
  logic                      issue_busy;
  logic                      launched;
  logic [PAYLOAD_WIDTH-1:0]  pend_payload;
  logic [SLOT_WIDTH-1:0]     pend_tag;

  // Tags the testbench believes are free, used to spot an issue that must stall.
  logic [SLOT_COUNT:1]       free_model;

  tag_manager_top u_tag_manager_top (
    .clk         (clk),
    .rst         (rst),
    .cfg_req     (cfg_req),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_ack     (cfg_ack),
    .cfg_rdata   (cfg_rdata),
    .iss_req     (iss_req),
    .iss_payload (iss_payload),
    .iss_ack     (iss_ack),
    .iss_tag     (iss_tag),
    .ret_req     (ret_req),
    .ret_tag     (ret_tag),
    .ret_ack     (ret_ack),
    .ret_payload (ret_payload)
  );

  tag_manager_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr),
    .cfg_ack     (cfg_ack),
    .cfg_rdata   (cfg_rdata),
    .exp_cfg     (exp_cfg),
    .iss_ack     (iss_ack),
    .iss_tag     (iss_tag),
    .exp_tag     (exp_tag),
    .ret_ack     (ret_ack),
    .ret_tag     (ret_tag),
    .ret_payload (ret_payload),
    .exp_payload (exp_payload),
    .pass_count  (pass_count),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
    $display("=== FAIL ===");
    $finish;
  end

  // ##################################################
  // Data file and handshakes
  // ##################################################

  task automatic load_testdata(output logic ok);
    int                       fd;
    int                       n;
    logic [63:0]              word;
    logic [8*128-1:0]         rest;
    logic [PAYLOAD_WIDTH-1:0] a;
    logic [PAYLOAD_WIDTH-1:0] b;
    ok = 1'b0;
    fd = $fopen(TESTDATA, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", word);
        if (n == 1) begin
          if (word[7:0] == "#") begin
            n = $fgets(rest, fd);
          end else begin
            n = $fscanf(fd, "%h %h", a, b);
            op_q.push_back(word[7:0]);
            arg_q.push_back(a);
            val_q.push_back(b);
          end
        end
      end
      $fclose(fd);
      ok = (op_q.size() > 0);
    end
  endtask

  task automatic cfg_access(input logic wr, input logic [CFG_ADDR_WIDTH-1:0] addr,
                            input logic [PAYLOAD_WIDTH-1:0] data);
    @(posedge clk);
    #2;
    cfg_write = wr;
    cfg_addr  = addr;
    cfg_wdata = data;
    exp_cfg   = data;
    cfg_req   = 1'b1;
    do begin
      @(posedge clk);
      #2;
    end while (!cfg_ack);
    cfg_req = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (cfg_ack);
  endtask

  task automatic issue_tag(input logic [PAYLOAD_WIDTH-1:0] payload,
                           input logic [SLOT_WIDTH-1:0] tag);
    @(posedge clk);
    #2;
    iss_payload = payload;
    exp_tag     = tag;
    iss_req     = 1'b1;
    do begin
      @(posedge clk);
      #2;
    end while (!iss_ack);
    iss_req = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (iss_ack);
  endtask

  task automatic retire_tag(input logic [SLOT_WIDTH-1:0] tag,
                            input logic [PAYLOAD_WIDTH-1:0] payload);
    @(posedge clk);
    #2;
    ret_tag     = tag;
    exp_payload = payload;
    ret_req     = 1'b1;
    do begin
      @(posedge clk);
      #2;
    end while (!ret_ack);
    ret_req = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (ret_ack);
  endtask

  initial begin
    rst             = 1'b1;
    cfg_req         = 1'b0;
    cfg_write       = 1'b0;
    cfg_addr        = '0;
    cfg_wdata       = '0;
    iss_req         = 1'b0;
    iss_payload     = '0;
    ret_req         = 1'b0;
    ret_tag         = '0;
    exp_cfg         = '0;
    exp_tag         = '0;
    exp_payload     = '0;
    free_model      = '0;
    issue_busy      = 1'b0;
    expected_checks = 0;
    bad_lines       = 0;
    load_testdata(loaded);
    if (!loaded) begin
      $display("Could not read any operation from %s", TESTDATA);
      $display("=== FAIL ===");
      $finish;
    end else begin
      cycle_limit = op_q.size() * CYCLES_PER_LINE + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst = 1'b0;
      for (int k = 0; k < op_q.size(); k++) begin
        launched = 1'b0;
        case (op_q[k])
          "W": begin
            cfg_access(1'b1, arg_q[k][CFG_ADDR_WIDTH-1:0], val_q[k]);
            if (arg_q[k][CFG_ADDR_WIDTH-1:0] == CFG_ADDR_POOL) begin
              for (int i = 1; i <= SLOT_COUNT; i++) begin
                free_model[i] = (i <= int'(val_q[k]));
              end
            end
          end
          "R": begin
            expected_checks++;
            cfg_access(1'b0, arg_q[k][CFG_ADDR_WIDTH-1:0], val_q[k]);
          end
          "I": begin
            expected_checks++;
            pend_payload = arg_q[k];
            pend_tag     = val_q[k][SLOT_WIDTH-1:0];
            if (free_model == '0) begin
              // Pool is empty, so the next line has to run beside this issue.
              issue_busy = 1'b1;
              launched   = 1'b1;
              fork
                begin
                  issue_tag(pend_payload, pend_tag);
                  free_model[pend_tag] = 1'b0;
                  issue_busy = 1'b0;
                end
              join_none
            end else begin
              issue_tag(pend_payload, pend_tag);
              free_model[pend_tag] = 1'b0;
            end
          end
          "T": begin
            expected_checks++;
            retire_tag(arg_q[k][SLOT_WIDTH-1:0], val_q[k]);
            free_model[arg_q[k][SLOT_WIDTH-1:0]] = 1'b1;
          end
          default: begin
            bad_lines++;
            $display("Unknown operation '%c' on data line %0d", op_q[k], k + 1);
          end
        endcase
        if (!launched) begin
          wait (!issue_busy);
        end
      end
      repeat (2) @(posedge clk);
      $display("Done: %0d passed, %0d failed, %0d expected, %0d bad lines, %0d assertion fails",
               pass_count, error_count, expected_checks, bad_lines,
               u_tag_manager_top.u_tag_manager_asserts.fail_count);
      if (error_count == 0 && pass_count == expected_checks && bad_lines == 0 &&
          u_tag_manager_top.u_tag_manager_asserts.fail_count == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

//--- sim/tag_manager_asserts.sv
`timescale 1ns/1ps

module tag_manager_asserts (
  input logic                           clk,
  input logic                           rst,
  input logic                           cfg_req,
  input logic                           cfg_ack,
  input logic                           iss_req,
  input logic                           iss_ack,
  input logic [tag_pkg::SLOT_WIDTH-1:0] iss_tag,
  input logic                           ret_req,
  input logic                           ret_ack
);

  import tag_pkg::*;

  int unsigned fail_count = 0;

  // An ack rises only on a clock edge where its request is high.
  cfg_ack_rise: assert property (@(posedge clk) disable iff (rst)
                                 $rose(cfg_ack) |-> $past(cfg_req))
    else begin
      fail_count++;
      $error("cfg_ack rose without cfg_req");
    end
  iss_ack_rise: assert property (@(posedge clk) disable iff (rst)
                                 $rose(iss_ack) |-> $past(iss_req))
    else begin
      fail_count++;
      $error("iss_ack rose without iss_req");
    end
  ret_ack_rise: assert property (@(posedge clk) disable iff (rst)
                                 $rose(ret_ack) |-> $past(ret_req))
    else begin
      fail_count++;
      $error("ret_ack rose without ret_req");
    end

  // An ack falls only once its request was already low.
  cfg_ack_fall: assert property (@(posedge clk) disable iff (rst)
                                 $fell(cfg_ack) |-> !$past(cfg_req))
    else begin
      fail_count++;
      $error("cfg_ack fell while cfg_req was high");
    end
  iss_ack_fall: assert property (@(posedge clk) disable iff (rst)
                                 $fell(iss_ack) |-> !$past(iss_req))
    else begin
      fail_count++;
      $error("iss_ack fell while iss_req was high");
    end
  ret_ack_fall: assert property (@(posedge clk) disable iff (rst)
                                 $fell(ret_ack) |-> !$past(ret_req))
    else begin
      fail_count++;
      $error("ret_ack fell while ret_req was high");
    end

  tag_range: assert property (@(posedge clk) disable iff (rst)
                              iss_ack |-> (iss_tag != '0 && iss_tag <= SLOT_WIDTH'(SLOT_COUNT)))
    else begin
      fail_count++;
      $error("iss_tag %0d out of range", iss_tag);
    end

endmodule

bind tag_manager_top tag_manager_asserts u_tag_manager_asserts (
  .clk     (clk),
  .rst     (rst),
  .cfg_req (cfg_req),
  .cfg_ack (cfg_ack),
  .iss_req (iss_req),
  .iss_ack (iss_ack),
  .iss_tag (iss_tag),
  .ret_req (ret_req),
  .ret_ack (ret_ack)
);

//--- sim/tag_manager_checker.sv
`timescale 1ns/1ps

module tag_manager_checker (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               cfg_write,
  input  logic [tag_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic                               cfg_ack,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0]  cfg_rdata,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0]  exp_cfg,

  input  logic                               iss_ack,
  input  logic [tag_pkg::SLOT_WIDTH-1:0]     iss_tag,
  input  logic [tag_pkg::SLOT_WIDTH-1:0]     exp_tag,

  input  logic                               ret_ack,
  input  logic [tag_pkg::SLOT_WIDTH-1:0]     ret_tag,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0]  ret_payload,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0]  exp_payload,

  output int                                 pass_count,
  output int                                 error_count
);

  import tag_pkg::*;

  logic cfg_ack_d;
  logic iss_ack_d;
  logic ret_ack_d;

  task automatic compare(input string what, input logic [PAYLOAD_WIDTH-1:0] got,
                         input logic [PAYLOAD_WIDTH-1:0] exp);
    if (got === exp) begin
      pass_count++;
      $display("[ok]    %0t: %s = %h", $time, what, got);
    end else begin
      error_count++;
      $display("[ERROR] %0t: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Results are taken on the first clock edge that sees an ack high.
  always @(posedge clk) begin
    if (rst) begin
      cfg_ack_d   <= 1'b0;
      iss_ack_d   <= 1'b0;
      ret_ack_d   <= 1'b0;
      pass_count  = 0;
      error_count = 0;
    end else begin
      cfg_ack_d <= cfg_ack;
      iss_ack_d <= iss_ack;
      ret_ack_d <= ret_ack;
      if (cfg_ack && !cfg_ack_d) begin
        if (cfg_write) begin
          $display("[ok]    %0t: cfg write to address %0d", $time, cfg_addr);
        end else begin
          compare($sformatf("cfg read address %0d", cfg_addr), cfg_rdata, exp_cfg);
        end
      end
      if (iss_ack && !iss_ack_d) begin
        compare("issued tag", PAYLOAD_WIDTH'(iss_tag), PAYLOAD_WIDTH'(exp_tag));
      end
      if (ret_ack && !ret_ack_d) begin
        compare($sformatf("payload of tag %0d", ret_tag), ret_payload, exp_payload);
      end
    end
  end

endmodule

//--- source/tag_manager_top.sv
`timescale 1ns/1ps

module tag_manager_top (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               cfg_req,
  input  logic                               cfg_write,
  input  logic [tag_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0]  cfg_wdata,
  output logic                               cfg_ack,
  output logic [tag_pkg::PAYLOAD_WIDTH-1:0]  cfg_rdata,

  input  logic                               iss_req,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0]  iss_payload,
  output logic                               iss_ack,
  output logic [tag_pkg::SLOT_WIDTH-1:0]     iss_tag,

  input  logic                               ret_req,
  input  logic [tag_pkg::SLOT_WIDTH-1:0]     ret_tag,
  output logic                               ret_ack,
  output logic [tag_pkg::PAYLOAD_WIDTH-1:0]  ret_payload
);

  import tag_pkg::*;

  logic [SLOT_WIDTH-1:0]    init_slots;
  logic                     init_valid;
  logic [SLOT_WIDTH-1:0]    slot_count;
  logic                     enq_err;
  logic [SLOT_WIDTH-1:0]    slot_out;
  logic                     slot_out_valid;
  logic                     slot_out_pop;
  logic [SLOT_WIDTH-1:0]    slot_in;
  logic                     slot_in_valid;
  logic                     ctx_wr_en;
  logic [SLOT_WIDTH-1:0]    ctx_wr_tag;
  logic [PAYLOAD_WIDTH-1:0] ctx_wr_data;
  logic [SLOT_WIDTH-1:0]    ctx_rd_tag;
  logic [PAYLOAD_WIDTH-1:0] ctx_rd_data;

  tag_cfg_regs u_tag_cfg_regs (
    .clk        (clk),
    .rst        (rst),
    .cfg_req    (cfg_req),
    .cfg_write  (cfg_write),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_ack    (cfg_ack),
    .cfg_rdata  (cfg_rdata),
    .slot_count (slot_count),
    .enq_err    (enq_err),
    .init_slots (init_slots),
    .init_valid (init_valid)
  );

  slot_keeper u_slot_keeper (
    .clk            (clk),
    .rst            (rst),
    .init_slots     (init_slots),
    .init_valid     (init_valid),
    .slot_in        (slot_in),
    .slot_in_valid  (slot_in_valid),
    .slot_out       (slot_out),
    .slot_out_valid (slot_out_valid),
    .slot_out_pop   (slot_out_pop),
    .slot_count     (slot_count),
    .enq_err        (enq_err)
  );

  tag_issue u_tag_issue (
    .clk            (clk),
    .rst            (rst),
    .iss_req        (iss_req),
    .iss_payload    (iss_payload),
    .iss_ack        (iss_ack),
    .iss_tag        (iss_tag),
    .slot_out       (slot_out),
    .slot_out_valid (slot_out_valid),
    .slot_out_pop   (slot_out_pop),
    .ctx_wr_en      (ctx_wr_en),
    .ctx_wr_tag     (ctx_wr_tag),
    .ctx_wr_data    (ctx_wr_data)
  );

  tag_context u_tag_context (
    .clk         (clk),
    .ctx_wr_en   (ctx_wr_en),
    .ctx_wr_tag  (ctx_wr_tag),
    .ctx_wr_data (ctx_wr_data),
    .ctx_rd_tag  (ctx_rd_tag),
    .ctx_rd_data (ctx_rd_data)
  );

  tag_retire u_tag_retire (
    .clk           (clk),
    .rst           (rst),
    .ret_req       (ret_req),
    .ret_tag       (ret_tag),
    .ret_ack       (ret_ack),
    .ret_payload   (ret_payload),
    .ctx_rd_tag    (ctx_rd_tag),
    .ctx_rd_data   (ctx_rd_data),
    .slot_in       (slot_in),
    .slot_in_valid (slot_in_valid)
  );

endmodule

//--- source/tag_retire.sv
`timescale 1ns/1ps

module tag_retire (
  input  logic                              clk,
  input  logic                              rst,

  input  logic                              ret_req,
  input  logic [tag_pkg::SLOT_WIDTH-1:0]    ret_tag,
  output logic                              ret_ack,
  output logic [tag_pkg::PAYLOAD_WIDTH-1:0] ret_payload,

  output logic [tag_pkg::SLOT_WIDTH-1:0]    ctx_rd_tag,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0] ctx_rd_data,

  output logic [tag_pkg::SLOT_WIDTH-1:0]    slot_in,
  output logic                              slot_in_valid
);

  import tag_pkg::*;

  logic                  rd_stage;
  logic                  load_stage;
  logic                  free_stage;
  logic                  ack_r;
  logic                  idle;
  logic [SLOT_WIDTH-1:0] tag_r;

  assign idle = !(rd_stage || load_stage || free_stage || ack_r);

  // ##################################################
  // Read, load, free, then ack
  // ##################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_stage   <= 1'b0;
      load_stage <= 1'b0;
      free_stage <= 1'b0;
      ack_r      <= 1'b0;
    end else begin
      rd_stage   <= idle && ret_req;
      load_stage <= rd_stage;
      free_stage <= load_stage;
      if (free_stage) begin
        ack_r <= 1'b1;
      end else if (!ret_req) begin
        ack_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (idle && ret_req) begin
      tag_r <= ret_tag;
    end
    // Context data is valid in the cycle after the tag was presented.
    if (load_stage) begin
      ret_payload <= ctx_rd_data;
    end
  end

  assign ctx_rd_tag    = tag_r;
  assign slot_in       = tag_r;
  assign slot_in_valid = free_stage;
  assign ret_ack       = ack_r;

endmodule

//--- source/tag_context.sv
`timescale 1ns/1ps

module tag_context (
  input  logic                              clk,

  input  logic                              ctx_wr_en,
  input  logic [tag_pkg::SLOT_WIDTH-1:0]    ctx_wr_tag,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0] ctx_wr_data,

  input  logic [tag_pkg::SLOT_WIDTH-1:0]    ctx_rd_tag,
  output logic [tag_pkg::PAYLOAD_WIDTH-1:0] ctx_rd_data
);

  import tag_pkg::*;

  logic [PAYLOAD_WIDTH-1:0] ctx_mem [1:SLOT_COUNT];

  function automatic logic tag_ok(input logic [SLOT_WIDTH-1:0] tag);
    return (tag != '0) && (tag <= SLOT_WIDTH'(SLOT_COUNT));
  endfunction

  always_ff @(posedge clk) begin
    if (ctx_wr_en && tag_ok(ctx_wr_tag)) begin
      ctx_mem[ctx_wr_tag] <= ctx_wr_data;
    end
  end

  // Registered read, one cycle behind ctx_rd_tag.
  always_ff @(posedge clk) begin
    if (tag_ok(ctx_rd_tag)) begin
      ctx_rd_data <= ctx_mem[ctx_rd_tag];
    end else begin
      ctx_rd_data <= '0;
    end
  end

endmodule

//--- source/tag_issue.sv
`timescale 1ns/1ps

module tag_issue (
  input  logic                              clk,
  input  logic                              rst,

  input  logic                              iss_req,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0] iss_payload,
  output logic                              iss_ack,
  output logic [tag_pkg::SLOT_WIDTH-1:0]    iss_tag,

  input  logic [tag_pkg::SLOT_WIDTH-1:0]    slot_out,
  input  logic                              slot_out_valid,
  output logic                              slot_out_pop,

  output logic                              ctx_wr_en,
  output logic [tag_pkg::SLOT_WIDTH-1:0]    ctx_wr_tag,
  output logic [tag_pkg::PAYLOAD_WIDTH-1:0] ctx_wr_data
);

  import tag_pkg::*;

  // ##################################################
  // One-hot sequence: claim, settle, ack
  // ##################################################

  logic                  claim;
  logic                  settle;
  logic                  ack_r;
  logic                  idle;
  logic                  take;
  logic [SLOT_WIDTH-1:0] tag_r;

  assign idle = !(claim || settle || ack_r);

  // Claim waits here for as long as the pool is empty.
  assign take = claim && slot_out_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      claim  <= 1'b0;
      settle <= 1'b0;
      ack_r  <= 1'b0;
    end else begin
      if (idle && iss_req) begin
        claim <= 1'b1;
      end else if (take) begin
        claim <= 1'b0;
      end
      settle <= take;
      if (settle) begin
        ack_r <= 1'b1;
      end else if (!iss_req) begin
        ack_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      tag_r <= slot_out;
    end
  end

  // Pop and context write share the single claim cycle.
  assign slot_out_pop = take;
  assign ctx_wr_en    = take;
  assign ctx_wr_tag   = slot_out;
  assign ctx_wr_data  = iss_payload;

  assign iss_ack = ack_r;
  assign iss_tag = tag_r;

endmodule

//--- source/tag_cfg_regs.sv
`timescale 1ns/1ps

module tag_cfg_regs (
  input  logic                               clk,
  input  logic                               rst,

  input  logic                               cfg_req,
  input  logic                               cfg_write,
  input  logic [tag_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [tag_pkg::PAYLOAD_WIDTH-1:0]  cfg_wdata,
  output logic                               cfg_ack,
  output logic [tag_pkg::PAYLOAD_WIDTH-1:0]  cfg_rdata,

  input  logic [tag_pkg::SLOT_WIDTH-1:0]     slot_count,
  input  logic                               enq_err,
  output logic [tag_pkg::SLOT_WIDTH-1:0]     init_slots,
  output logic                               init_valid
);

  import tag_pkg::*;

  logic                     req_d;
  logic                     step1;
  logic                     step2;
  logic [SLOT_WIDTH-1:0]    pool_size;
  logic [SLOT_WIDTH-1:0]    clamped;
  logic                     err_flag;
  logic                     wr_pool;
  logic                     wr_clear;
  logic [PAYLOAD_WIDTH-1:0] read_word;

  assign clamped = (cfg_wdata > PAYLOAD_WIDTH'(SLOT_COUNT)) ? SLOT_WIDTH'(SLOT_COUNT)
                                                           : cfg_wdata[SLOT_WIDTH-1:0];

  // Writes take effect one cycle after the request edge.
  assign wr_pool  = step1 && cfg_write && (cfg_addr == CFG_ADDR_POOL);
  assign wr_clear = step1 && cfg_write && (cfg_addr == CFG_ADDR_STATUS) && cfg_wdata[0];

  always_comb begin
    case (cfg_addr)
      CFG_ADDR_POOL:   read_word = PAYLOAD_WIDTH'(pool_size);
      CFG_ADDR_COUNT:  read_word = PAYLOAD_WIDTH'(slot_count);
      CFG_ADDR_STATUS: read_word = {{(PAYLOAD_WIDTH-1){1'b0}}, err_flag};
      default:         read_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_d      <= 1'b0;
      step1      <= 1'b0;
      step2      <= 1'b0;
      cfg_ack    <= 1'b0;
      init_valid <= 1'b0;
      pool_size  <= '0;
      err_flag   <= 1'b0;
    end else begin
      req_d      <= cfg_req;
      step1      <= cfg_req && !req_d;
      step2      <= step1;
      init_valid <= wr_pool;
      if (wr_pool) begin
        pool_size <= clamped;
      end
      // A new error report wins over a clear in the same cycle.
      if (enq_err) begin
        err_flag <= 1'b1;
      end else if (wr_pool || wr_clear) begin
        err_flag <= 1'b0;
      end
      if (step2) begin
        cfg_ack <= 1'b1;
      end else if (!cfg_req) begin
        cfg_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step2) begin
      cfg_rdata <= read_word;
    end
  end

  assign init_slots = pool_size;

endmodule

//--- source/slot_keeper.sv
`timescale 1ns/1ps

module slot_keeper (
  input  logic                           clk,
  input  logic                           rst,

  input  logic [tag_pkg::SLOT_WIDTH-1:0] init_slots,
  input  logic                           init_valid,

  input  logic [tag_pkg::SLOT_WIDTH-1:0] slot_in,
  input  logic                           slot_in_valid,

  output logic [tag_pkg::SLOT_WIDTH-1:0] slot_out,
  output logic                           slot_out_valid,
  input  logic                           slot_out_pop,

  output logic [tag_pkg::SLOT_WIDTH-1:0] slot_count,
  output logic                           enq_err
);

  import tag_pkg::*;

  // One bit per tag, set while the tag is free.
  logic [SLOT_COUNT:1]   free_map;
  logic [SLOT_WIDTH-1:0] lowest;
  logic [SLOT_WIDTH-1:0] free_cnt;

  logic in_range;
  logic enque;
  logic dup;
  logic deque;
  logic accept;

  logic dup_r;
  logic enq_err_r;

  // Tag 0 and anything past SLOT_COUNT are dropped on return.
  assign in_range = (slot_in != '0) && (slot_in <= SLOT_WIDTH'(SLOT_COUNT));
  assign enque    = slot_in_valid && in_range;
  assign dup      = enque && free_map[slot_in];
  assign accept   = enque && !dup;
  assign deque    = slot_out_pop && slot_out_valid;

  // Priority pick of the lowest free tag.
  always_comb begin
    lowest = '0;
    for (int i = SLOT_COUNT; i >= 1; i--) begin
      if (free_map[i]) begin
        lowest = SLOT_WIDTH'(i);
      end
    end
  end

  // ##################################################
  // Pool state
  // ##################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      free_map <= '0;
      free_cnt <= '0;
    end else if (init_valid) begin
      for (int i = 1; i <= SLOT_COUNT; i++) begin
        free_map[i] <= (i <= int'(init_slots));
      end
      free_cnt <= init_slots;
    end else begin
      if (deque) begin
        free_map[lowest] <= 1'b0;
      end
      // A duplicate return leaves the map alone, so a pop of the same
      // tag in this cycle still takes it out.
      if (accept) begin
        free_map[slot_in] <= 1'b1;
      end
      case ({accept, deque})
        2'b10:   free_cnt <= free_cnt + 1'b1;
        2'b01:   free_cnt <= free_cnt - 1'b1;
        default: free_cnt <= free_cnt;
      endcase
    end
  end

  // Duplicate return shows up on enq_err two cycles later.
  always_ff @(posedge clk) begin
    if (rst) begin
      dup_r     <= 1'b0;
      enq_err_r <= 1'b0;
    end else begin
      dup_r     <= dup;
      enq_err_r <= dup_r;
    end
  end

  assign slot_out       = lowest;
  assign slot_out_valid = |free_map;
  assign slot_count     = free_cnt;
  assign enq_err        = enq_err_r;

endmodule

//--- source/tag_pkg.sv
package tag_pkg;

  // ##################################################
  // Tag pool sizing
  // ##################################################

  // Tags run from 1 to SLOT_COUNT. Tag 0 is never issued.
  localparam int SLOT_COUNT = 8;

  // Wide enough for a tag and for a free count of 0 to SLOT_COUNT.
  localparam int SLOT_WIDTH = 4;

  // Request payload and host data word.
  localparam int PAYLOAD_WIDTH = 16;

  // ##################################################
  // Host register map
  // ##################################################

  localparam int CFG_ADDR_WIDTH = 2;

  localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ADDR_POOL   = 2'd0;
  localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ADDR_COUNT  = 2'd1;
  localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ADDR_STATUS = 2'd2;

endpackage
